// File: include/dataCache_config.svh
// ====================
// Data cache geometry
// Set count, block size and the widths derived from them
// ====================

`ifndef DATACACHE_CONFIG_SVH
`define DATACACHE_CONFIG_SVH

// Power-of-two set count
`define DC_SETS 4

// Power-of-two block size in words
`define DC_BLOCK_WORDS 4

`define DC_SET_BITS $clog2(`DC_SETS)
`define DC_OFFSET_BITS $clog2(`DC_BLOCK_WORDS)

// Tag takes what the set and offset leave of the 30-bit word address
`define DC_TAG_BITS (30 - `DC_SET_BITS - `DC_OFFSET_BITS)

`endif

// File: hdl/dataCachePkg.sv
// ====================
// Data cache types
// Widths, request structs and controller states
// ====================

package dataCachePkg;

    `include "dataCache_config.svh"

    typedef logic [31:0] wordT;
    typedef logic [31:0] addrT;
    typedef logic [`DC_TAG_BITS-1:0] tagT;
    typedef logic [`DC_SET_BITS-1:0] setT;
    typedef logic [`DC_OFFSET_BITS-1:0] offsetT;
    typedef logic [3:0] byteMaskT;
    typedef wordT [`DC_BLOCK_WORDS-1:0] blockT;

    // Core memory stage access
    typedef struct packed {
        addrT     addr;
        wordT     wd;
        byteMaskT byteMask;
        logic     read;
        logic     write;
    } cpuReqT;

    // Single-beat bus request held until ready
    typedef struct packed {
        addrT addr;
        wordT wd;
        logic request;
        logic write;
    } busReqT;

    typedef enum logic [1:0] {IDLE, WRITEBACK, FETCH, REFILL} ctrlStateT;

endpackage

// File: hdl/cacheWays.sv
// ====================
// Two-way cache storage
// Blocks, tags, valid, dirty and LRU state with hit detection
// ====================

`timescale 1ns/1ps

`include "dataCache_config.svh"

module cacheWays import dataCachePkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  setT      set,
    input  tagT      tag,
    input  offsetT   wordSel,
    input  wordT     wd,
    input  byteMaskT byteMask,
    input  logic     writeHit,
    input  logic     fillWe,
    input  logic     install,
    output logic     hit,
    output logic     victimDirty,
    output tagT      victimTag,
    output wordT     hitData,
    output wordT     victimData
);

    // Block and tag storage indexed by way then set
    blockT blocks [2][`DC_SETS];
    tagT   tags [2][`DC_SETS];

    // Per-line status bits
    logic [1:0][`DC_SETS-1:0] valid;
    logic [1:0][`DC_SETS-1:0] dirty;

    // One bit per set naming the way to replace next
    logic [`DC_SETS-1:0] lru;

    logic [1:0] wayHit;
    logic       hitWay;
    logic       victimWay;

    // Tag compare in both ways
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayHit[w] = valid[w][set] && (tags[w][set] == tag);
        end
    end

    assign hit    = |wayHit;
    assign hitWay = wayHit[1];

    assign hitData = blocks[hitWay][set][wordSel];

    // Victim chosen by the LRU bit
    assign victimWay   = lru[set];
    assign victimTag   = tags[victimWay][set];
    assign victimDirty = valid[victimWay][set] && dirty[victimWay][set];
    assign victimData  = blocks[victimWay][set][wordSel];

    // Data and tag arrays
    always_ff @(posedge clk) begin
        if (fillWe) begin
            // Whole word from the bus into the victim way
            blocks[victimWay][set][wordSel] <= wd;
        end else if (writeHit) begin
            for (int b = 0; b < 4; b++) begin
                if (byteMask[b]) begin
                    blocks[hitWay][set][wordSel][8*b +: 8] <= wd[8*b +: 8];
                end
            end
        end

        if (install) begin
            tags[victimWay][set] <= tag;
        end
    end

    // Status bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else begin
            if (install) begin
                // Fresh line from memory is clean
                valid[victimWay][set] <= 1'b1;
                dirty[victimWay][set] <= 1'b0;
            end

            if (writeHit) begin
                dirty[hitWay][set] <= 1'b1;
            end

            // Point away from the way just used
            if (hit) begin
                lru[set] <= ~hitWay;
            end
        end
    end

endmodule

// File: hdl/cacheController.sv
// ====================
// Data cache controller
// Miss FSM with write-back and refill sequencing
// ====================

`timescale 1ns/1ps

`include "dataCache_config.svh"

module cacheController import dataCachePkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      read,
    input  logic      write,
    input  logic      hit,
    input  logic      victimDirty,
    input  logic      busReady,
    output ctrlStateT state,
    output offsetT    wordCount,
    output logic      fillWe,
    output logic      install,
    output logic      useVictimTag,
    output logic      busRequest,
    output logic      busWrite,
    output logic      stall
);

    localparam offsetT lastWord = offsetT'(`DC_BLOCK_WORDS - 1);

    ctrlStateT nextState;

    logic miss;
    logic beatDone;
    logic lastBeat;

    // Access present but neither way matched
    assign miss = (read || write) && !hit;

    // A bus transfer completes on request and ready together
    assign beatDone = busRequest && busReady;
    assign lastBeat = beatDone && (wordCount == lastWord);

    // State register
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // Word counter shared by write-back and fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            wordCount <= '0;
        end else if (beatDone) begin
            if (wordCount == lastWord) begin
                wordCount <= '0;
            end else begin
                wordCount <= wordCount + 1'b1;
            end
        end
    end

    // Next state
    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (miss) begin
                    // Dirty victim has to reach memory first
                    if (victimDirty) begin
                        nextState = WRITEBACK;
                    end else begin
                        nextState = FETCH;
                    end
                end
            end
            WRITEBACK: begin
                if (lastBeat) begin
                    nextState = FETCH;
                end
            end
            FETCH: begin
                if (lastBeat) begin
                    nextState = REFILL;
                end
            end
            REFILL: begin
                nextState = IDLE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    // Outputs decoded from the state
    always_comb begin
        busRequest   = 1'b0;
        busWrite     = 1'b0;
        useVictimTag = 1'b0;
        fillWe       = 1'b0;
        install      = 1'b0;
        case (state)
            WRITEBACK: begin
                busRequest   = 1'b1;
                busWrite     = 1'b1;
                useVictimTag = 1'b1;
            end
            FETCH: begin
                busRequest = 1'b1;
                // Each arriving word lands in the victim way
                fillWe     = busReady;
            end
            REFILL: begin
                install = 1'b1;
            end
            default: begin
                busRequest = 1'b0;
            end
        endcase
    end

    // Stall rises in the same cycle as the miss
    assign stall = (state != IDLE) || miss;

endmodule

// File: hdl/dataWritebackCache.sv
// ====================
// Write-back data cache
// Address split, write merge and read select around the ways
// ====================

`timescale 1ns/1ps

module dataWritebackCache import dataCachePkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  cpuReqT req,
    input  wordT   hRData,
    input  logic   busReady,
    output wordT   rd,
    output logic   stall,
    output busReqT bus
);

    tagT       reqTag;
    setT       reqSet;
    offsetT    reqOffset;
    offsetT    wordCount;
    offsetT    wordSel;
    tagT       victimTag;
    tagT       busTag;
    wordT      hitData;
    wordT      victimData;
    wordT      fillData;
    wordT      cacheWd;
    ctrlStateT state;
    logic      hit;
    logic      victimDirty;
    logic      writeHit;
    logic      fillWe;
    logic      install;
    logic      useVictimTag;
    logic      busRequest;
    logic      busWrite;

    // Physical address straight from the core without the byte bits
    assign {reqTag, reqSet, reqOffset} = req.addr[31:2];

    // Counter drives the word index while a miss is in progress
    assign wordSel = (state == IDLE) ? reqOffset : wordCount;

    assign writeHit = req.write && hit;

    // Core bytes override fill data for the word being written
    always_comb begin
        fillData = hRData;
        if (req.write && (wordCount == reqOffset)) begin
            for (int b = 0; b < 4; b++) begin
                if (req.byteMask[b]) begin
                    fillData[8*b +: 8] = req.wd[8*b +: 8];
                end
            end
        end
    end

    assign cacheWd = fillWe ? fillData : req.wd;

    cacheWays i_ways (
        .clk         (clk),
        .reset       (reset),
        .set         (reqSet),
        .tag         (reqTag),
        .wordSel     (wordSel),
        .wd          (cacheWd),
        .byteMask    (req.byteMask),
        .writeHit    (writeHit),
        .fillWe      (fillWe),
        .install     (install),
        .hit         (hit),
        .victimDirty (victimDirty),
        .victimTag   (victimTag),
        .hitData     (hitData),
        .victimData  (victimData)
    );

    cacheController i_ctrl (
        .clk          (clk),
        .reset        (reset),
        .read         (req.read),
        .write        (req.write),
        .hit          (hit),
        .victimDirty  (victimDirty),
        .busReady     (busReady),
        .state        (state),
        .wordCount    (wordCount),
        .fillWe       (fillWe),
        .install      (install),
        .useVictimTag (useVictimTag),
        .busRequest   (busRequest),
        .busWrite     (busWrite),
        .stall        (stall)
    );

    // Write-back goes to the old block, fetch to the new one
    assign busTag = useVictimTag ? victimTag : reqTag;

    assign bus = '{
        addr:    {busTag, reqSet, wordCount, 2'b00},
        wd:      victimData,
        request: busRequest,
        write:   busWrite
    };

    assign rd = hitData;

endmodule

// File: testbench/dataCache_asserts.sv
// ====================
// Data cache bus and stall checks
// ====================

`timescale 1ns/1ps

module dataCacheAsserts import dataCachePkg::*; (
    input logic      clk,
    input logic      reset,
    input busReqT    bus,
    input logic      busReady,
    input logic      stall,
    input ctrlStateT state
);

    // A waiting transfer keeps its request, address and direction
    property busHeld;
        @(posedge clk) disable iff (reset)
            bus.request && !busReady |=>
                bus.request && $stable(bus.addr) && $stable(bus.write);
    endproperty

    // Write data stays put while a write waits
    property writeDataHeld;
        @(posedge clk) disable iff (reset)
            bus.request && bus.write && !busReady |=> $stable(bus.wd);
    endproperty

    property idleAfterReset;
        @(posedge clk) reset |=> !bus.request && !bus.write;
    endproperty

    // Back in IDLE after a refill the held access hits without stalling
    property stallEndsAfterRefill;
        @(posedge clk) disable iff (reset)
            state == REFILL |=> !stall;
    endproperty

    assert property (busHeld) else begin
        $error("bus request changed before busReady");
        dataCache_tb.assertFailures++;
    end

    assert property (writeDataHeld) else begin
        $error("bus write data changed before busReady");
        dataCache_tb.assertFailures++;
    end

    assert property (idleAfterReset) else begin
        $error("bus not idle after reset");
        dataCache_tb.assertFailures++;
    end

    assert property (stallEndsAfterRefill) else begin
        $error("stall still high in IDLE after a refill");
        dataCache_tb.assertFailures++;
    end

endmodule

// File: testbench/dataCache_tb.sv
// ====================
// Data cache testbench
// Bus memory model and directed tests against a reference memory
// ====================

`timescale 1ns/1ps

`include "dataCache_config.svh"

module dataCache_tb import dataCachePkg::*; ();

    localparam int memWordCount = 1024;
    localparam int timeoutCycles = 200;
    localparam addrT lineA = 32'h0000_0024;
    // One tag step within the same set
    localparam addrT tagStride = 32'h0000_0040;

    logic   clk;
    logic   reset;
    cpuReqT req;
    wordT   hRData;
    logic   busReady;
    wordT   rd;
    logic   stall;
    busReqT bus;

    wordT  memWords [memWordCount];
    wordT  refWords [memWordCount];
    int    delayTable [256];
    int    delayIndex;
    int    delayLeft;
    int    busReads;
    int    busWrites;
    addrT  writeAddrs [$];
    wordT  writeData [$];
    string testName;
    int    testErrors;
    int    errorCount;
    int    checkCount;
    int    testCount;
    int    assertFailures;

    dataWritebackCache i_dut (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .hRData   (hRData),
        .busReady (busReady),
        .rd       (rd),
        .stall    (stall),
        .bus      (bus)
    );

    bind dataWritebackCache dataCacheAsserts i_asserts (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Memory model that waits 0 to 3 cycles per beat
    always @(negedge clk) begin
        if (reset || !bus.request) begin
            busReady = 1'b0;
            delayLeft = -1;
        end else begin
            if (delayLeft < 0) begin
                delayLeft = delayTable[delayIndex % 256];
                delayIndex++;
            end
            if (delayLeft == 0) begin
                busReady = 1'b1;
                hRData = memWords[bus.addr[11:2]];
                delayLeft = -1;
            end else begin
                busReady = 1'b0;
                delayLeft--;
            end
        end
    end

    // Count completed beats and log the writes
    always @(posedge clk) begin
        if (!reset && bus.request && busReady) begin
            if (bus.write) begin
                memWords[bus.addr[11:2]] = bus.wd;
                writeAddrs.push_back(bus.addr);
                writeData.push_back(bus.wd);
                busWrites++;
            end else begin
                busReads++;
            end
        end
    end

    function automatic wordT mergeBytes(input wordT old, input wordT wd, input byteMaskT mask);
        wordT merged;
        merged = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                merged[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return merged;
    endfunction

    task automatic beginTest(input string name);
        testName = name;
        testErrors = 0;
        busReads = 0;
        busWrites = 0;
        writeAddrs.delete();
        writeData.delete();
    endtask

    task automatic endTest();
        testCount++;
        errorCount += testErrors;
        $display("%s finished with %0d errors", testName, testErrors);
    endtask

    task automatic checkWord(input string what, input wordT expected, input wordT actual);
        checkCount++;
        assert (actual === expected) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", testName, what, expected, actual);
            testErrors++;
        end
    endtask

    // Holds the strobe until the edge where stall is low
    task automatic access(input addrT addr, input logic isWrite, input wordT wd,
                          input byteMaskT mask, output wordT data);
        int cycles;
        @(negedge clk);
        req.addr = addr;
        req.wd = wd;
        req.byteMask = mask;
        req.read = !isWrite;
        req.write = isWrite;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (stall && cycles < timeoutCycles);
        if (stall) begin
            $display("Access to %h still stalled after %0d cycles", addr, cycles);
            $display("=== FAIL ===");
            $finish;
        end else begin
            data = rd;
            if (isWrite) begin
                refWords[addr[11:2]] = mergeBytes(refWords[addr[11:2]], wd, mask);
            end
            @(negedge clk);
            req.read = 1'b0;
            req.write = 1'b0;
        end
    endtask

    task automatic readCheck(input addrT addr, input string what);
        wordT data;
        access(addr, 1'b0, '0, '0, data);
        checkWord(what, refWords[addr[11:2]], data);
    endtask

    task automatic writeWord(input addrT addr, input wordT wd, input byteMaskT mask);
        wordT data;
        access(addr, 1'b1, wd, mask, data);
    endtask

    task automatic firstReadFill();
        beginTest("first read");
        @(posedge clk);
        checkWord("stall after reset", '0, wordT'(stall));
        checkWord("bus request after reset", '0, wordT'(bus.request));
        readCheck(lineA, "read data");
        checkWord("bus reads", `DC_BLOCK_WORDS, busReads);
        checkWord("bus writes", 0, busWrites);
        endTest();
    endtask

    task automatic blockRepeatRead();
        beginTest("repeat read");
        readCheck(lineA + 4, "read data");
        checkWord("bus beats", 0, busReads + busWrites);
        endTest();
    endtask

    task automatic partialWriteMerge();
        beginTest("partial write");
        writeWord(lineA, 32'h1234_5678, 4'b0101);
        readCheck(lineA, "merged data");
        checkWord("bus writes", 0, busWrites);
        endTest();
    endtask

    task automatic dirtyEviction();
        addrT blockBase;
        beginTest("dirty eviction");
        blockBase = lineA & ~addrT'(`DC_BLOCK_WORDS * 4 - 1);
        readCheck(lineA + tagStride, "second tag");
        readCheck(lineA + 2 * tagStride, "third tag");
        checkWord("bus writes", `DC_BLOCK_WORDS, busWrites);
        // Write-back runs word by word from the start of the block
        foreach (writeAddrs[i]) begin
            checkWord("write-back address", blockBase + 4 * i, writeAddrs[i]);
            checkWord("write-back data", refWords[blockBase[11:2] + i], writeData[i]);
        end
        busReads = 0;
        readCheck(lineA, "re-read");
        checkWord("re-read bus reads", `DC_BLOCK_WORDS, busReads);
        endTest();
    endtask

    task automatic cleanEviction();
        beginTest("clean eviction");
        readCheck(lineA + 3 * tagStride, "fourth tag");
        checkWord("bus reads", `DC_BLOCK_WORDS, busReads);
        checkWord("bus writes", 0, busWrites);
        endTest();
    endtask

    // Eight tags over every set and a final sweep of the region
    task automatic randomTraffic();
        addrT addr;
        beginTest("random traffic");
        for (int n = 0; n < 300; n++) begin
            addr = addrT'($urandom_range(127, 0)) << 2;
            if ($urandom_range(1, 0) == 1) begin
                writeWord(addr, $urandom(), byteMaskT'($urandom_range(15, 1)));
            end else begin
                readCheck(addr, "random read");
            end
        end
        for (int w = 0; w < 128; w++) begin
            readCheck(addrT'(w) << 2, "sweep read");
        end
        endTest();
    endtask

    initial begin
        void'($urandom(44));
        reset = 1'b1;
        req = '0;
        hRData = '0;
        busReady = 1'b0;
        delayIndex = 0;
        delayLeft = -1;
        errorCount = 0;
        checkCount = 0;
        testCount = 0;
        assertFailures = 0;
        for (int i = 0; i < 256; i++) begin
            delayTable[i] = $urandom_range(3, 0);
        end
        // Each word holds its byte address XOR a fixed pattern
        for (int i = 0; i < memWordCount; i++) begin
            memWords[i] = (addrT'(i) << 2) ^ 32'hA5A5_A5A5;
            refWords[i] = memWords[i];
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        firstReadFill();
        blockRepeatRead();
        partialWriteMerge();
        dirtyEviction();
        cleanEviction();
        randomTraffic();

        $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 testCount, checkCount, errorCount, assertFailures);
        if (errorCount == 0 && assertFailures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: legDataCache.f
+incdir+include
hdl/dataCachePkg.sv
hdl/cacheWays.sv
hdl/cacheController.sv
hdl/dataWritebackCache.sv
testbench/dataCache_asserts.sv
testbench/dataCache_tb.sv

// File: Bender.yml
package:
  name: legDataCache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/dataCachePkg.sv
      - hdl/cacheWays.sv
      - hdl/cacheController.sv
      - hdl/dataWritebackCache.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/dataCache_asserts.sv
      - testbench/dataCache_tb.sv
